//--- common/spatial_pkg.sv
/* shared types and constants for the steered audio path:
   sample and accumulator widths, control words, position codes, input structs */

package spatial_pkg;

  // ==============================
  // widths and constants
  // ==============================
  typedef logic [9:0]  sample_t;     // 10 bit audio sample
  typedef logic [10:0] accum_t;      // room for 2*1023, enough headroom
  typedef logic [31:0] ctrl_word_t;  // raw control word from host

  // modulator threshold, one sample period in clocks
  localparam logic [31:0] FULL_SCALE = 32'd1000;

  // opens and closes a position frame
  localparam logic [31:0] FRAME_MARKER = 32'd233333;

  localparam int NUM_CHANNELS = 8;  // speakers in the row

  // ==============================
  // source position codes
  // ==============================
  // codes 5..15 are not listed, steering treats them as front
  typedef enum logic [3:0] {
    pos_front       = 4'd0,
    pos_left_front  = 4'd1,
    pos_left        = 4'd2,
    pos_right_front = 4'd3,
    pos_right       = 4'd4
  } position_e;

  // ==============================
  // host input strobes
  // ==============================
  typedef struct packed {
    logic    valid;   // one cycle strobe
    sample_t sample;
  } audio_in_t;

  typedef struct packed {
    logic       valid;  // one cycle strobe, one word
    ctrl_word_t word;
  } ctrl_in_t;

endpackage

//--- design/sample_pacer.sv
/* sample period counter, raises a one cycle sample request per period */

`timescale 1ns/100ps

module sample_pacer #(
  parameter int unsigned SAMPLE_PERIOD = 1000  // clocks per audio sample
) (
  input  logic PWM_ADC_CLOCK_100M,
  input  logic arst_n,
  output logic sample_req
);

  // at least one bit even for a period of 1
  localparam int CNT_W = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(SAMPLE_PERIOD - 1);

  logic [CNT_W-1:0] period_cnt;  // free running
  logic             wrap;

  assign wrap = (period_cnt == LAST);

  // counter wraps at SAMPLE_PERIOD-1, request registered on the wrap edge
  // so the first strobe shows SAMPLE_PERIOD clocks after reset release
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
      sample_req <= 1'b0;
    end else begin
      if (wrap) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
      sample_req <= wrap;  // high for exactly one clock
    end
  end

endmodule

//--- modulator/sigma_delta_mod.sv
/* sample holding register and first order sigma-delta modulator,
   one density coded output bit per clock */

`timescale 1ns/100ps

module sigma_delta_mod (
  input  logic                  PWM_ADC_CLOCK_100M,
  input  logic                  arst_n,
  input  spatial_pkg::audio_in_t audio_in,
  output logic                  pulse_bit
);

  // threshold narrowed to accumulator width, 1000 fits in 11 bits
  localparam spatial_pkg::accum_t THRESH = spatial_pkg::accum_t'(spatial_pkg::FULL_SCALE);

  spatial_pkg::sample_t held_sample;  // last sample from host
  spatial_pkg::accum_t  accum;
  spatial_pkg::accum_t  sample_ext;   // sample widened to accum width
  logic                 overflow;

  // ==============================
  // sample hold
  // ==============================
  // strobe loads on its own edge, unrequested samples taken too
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      held_sample <= '0;
    end else if (audio_in.valid) begin
      held_sample <= audio_in.sample;
    end
  end

  assign sample_ext = {1'b0, held_sample};
  assign overflow   = (accum >= THRESH);  // crossed full scale

  // ==============================
  // accumulator
  // ==============================
  // ones density tracks held_sample / FULL_SCALE
  // peak value stays below 2048 for any 10 bit sample
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      accum     <= '0;
      pulse_bit <= 1'b0;
    end else if (overflow) begin
      pulse_bit <= 1'b1;
      accum     <= accum - THRESH + sample_ext;  // drop one quantum
    end else begin
      pulse_bit <= 1'b0;
      accum     <= accum + sample_ext;
    end
  end

endmodule

//--- design/position_framer.sv
/* control word frame tracker, marker words open and close a frame,
   position words inside a frame set the current source position */

`timescale 1ns/100ps

module position_framer (
  input  logic                   PWM_ADC_CLOCK_100M,
  input  logic                   arst_n,
  input  spatial_pkg::ctrl_in_t  ctrl_in,
  output spatial_pkg::position_e position
);

  typedef enum logic {
    st_out_frame = 1'b0,  // waiting for opening marker
    st_in_frame  = 1'b1   // position words accepted
  } frame_state_e;

  frame_state_e state;
  frame_state_e state_nxt;
  logic         is_marker;
  logic         load_pos;

  assign is_marker = (ctrl_in.word == spatial_pkg::FRAME_MARKER);

  // ==============================
  // frame FSM
  // ==============================
  always_comb begin
    state_nxt = state;
    if (ctrl_in.valid && is_marker) begin
      // marker toggles in/out of frame
      case (state)
        st_out_frame: state_nxt = st_in_frame;
        st_in_frame:  state_nxt = st_out_frame;
        default:      state_nxt = st_out_frame;
      endcase
    end
  end

  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_out_frame;
    end else begin
      state <= state_nxt;
    end
  end

  // only non-marker words inside a frame carry a position
  // stray words outside a frame are dropped
  assign load_pos = ctrl_in.valid && !is_marker && (state == st_in_frame);

  // ==============================
  // position register
  // ==============================
  // low nibble taken as is, unknown codes kept and read as front downstream
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      position <= spatial_pkg::pos_front;
    end else if (load_pos) begin
      position <= spatial_pkg::position_e'(ctrl_in.word[3:0]);
    end
  end

endmodule

//--- steering/beam_steer.sv
/* pulse stream delay line and per channel tap select by source position
   with right side positions mirroring the left side tap pattern */

`timescale 1ns/100ps

module beam_steer #(
  parameter int unsigned NEAR_STEP   = 4159,   // tap spacing for the front diagonals
  parameter int unsigned SIDE_STEP   = 5882,   // tap spacing for hard left and right
  parameter int unsigned DELAY_DEPTH = 41177   // must exceed 7*SIDE_STEP
) (
  input  logic                                PWM_ADC_CLOCK_100M,
  input  logic                                arst_n,
  input  logic                                pulse_bit,
  input  spatial_pkg::position_e              position,
  output logic [spatial_pkg::NUM_CHANNELS-1:0] speaker_out
);

  localparam int NCH   = spatial_pkg::NUM_CHANNELS;
  localparam int TAP_W = $clog2(DELAY_DEPTH + 1);  // index 0..DELAY_DEPTH

  logic [DELAY_DEPTH-1:0] delay_line;  // bit k = pulse_bit k+1 clocks ago
  logic [DELAY_DEPTH:0]   taps;        // tap k = pulse_bit delayed by k
  logic [TAP_W-1:0]       tap_sel [NCH];

  // tap 0 is the live modulator bit, so channel 0 lags it by one clock
  assign taps = {delay_line, pulse_bit};

  // ==============================
  // delay line
  // ==============================
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      delay_line <= '0;
    end else begin
      delay_line <= {delay_line[DELAY_DEPTH-2:0], pulse_bit};
    end
  end

  // ==============================
  // tap selection
  // ==============================
  // left positions delay the far channels more and right mirrors it
  always_comb begin
    int unsigned step;
    int unsigned rank;
    for (int c = 0; c < NCH; c++) begin
      step = 0;
      rank = c;
      case (position)
        spatial_pkg::pos_left_front: begin
          step = NEAR_STEP;
          rank = c;
        end
        spatial_pkg::pos_left: begin
          step = SIDE_STEP;
          rank = c;
        end
        spatial_pkg::pos_right_front: begin
          step = NEAR_STEP;
          rank = NCH - 1 - c;  // channel 7 is nearest
        end
        spatial_pkg::pos_right: begin
          step = SIDE_STEP;
          rank = NCH - 1 - c;
        end
        default: begin
          step = 0;  // front and unknown codes keep all channels in phase
          rank = c;
        end
      endcase
      tap_sel[c] = TAP_W'(step * rank);
    end
  end

  // ==============================
  // output register
  // ==============================
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      speaker_out <= '0;
    end else begin
      for (int c = 0; c < NCH; c++) begin
        speaker_out[c] <= taps[tap_sel[c]];
      end
    end
  end

endmodule

//--- design/spatial_audio_top.sv
/* steered audio output stage, pacer, modulator, position framer and
   delay line steering for eight speaker channels */

`timescale 1ns/100ps

module spatial_audio_top #(
  parameter int unsigned SAMPLE_PERIOD = 1000,   // 100 MHz / 100 kHz
  parameter int unsigned NEAR_STEP     = 4159,
  parameter int unsigned SIDE_STEP     = 5882,
  parameter int unsigned DELAY_DEPTH   = 41177
) (
  input  logic                                PWM_ADC_CLOCK_100M,
  input  logic                                arst_n,
  input  spatial_pkg::audio_in_t              audio_in,     // sample strobe
  input  spatial_pkg::ctrl_in_t               ctrl_in,      // control word strobe
  output logic                                sample_req,   // ask host for a sample
  output logic [spatial_pkg::NUM_CHANNELS-1:0] speaker_out
);

  // ==============================
  // internal wires
  // ==============================
  logic                   pulse_bit;  // modulator stream
  spatial_pkg::position_e position;   // current source position

  // ==============================
  // sample pacing
  // ==============================
  sample_pacer #(
    .SAMPLE_PERIOD (SAMPLE_PERIOD)
  ) u_sample_pacer (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .sample_req         (sample_req)
  );

  // ==============================
  // modulation
  // ==============================
  sigma_delta_mod u_sigma_delta_mod (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .audio_in           (audio_in),
    .pulse_bit          (pulse_bit)
  );

  // ==============================
  // position control
  // ==============================
  position_framer u_position_framer (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .ctrl_in            (ctrl_in),
    .position           (position)
  );

  // ==============================
  // steering
  // ==============================
  // tap spacing and depth come from the top, small values in simulation
  beam_steer #(
    .NEAR_STEP   (NEAR_STEP),
    .SIDE_STEP   (SIDE_STEP),
    .DELAY_DEPTH (DELAY_DEPTH)
  ) u_beam_steer (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .pulse_bit          (pulse_bit),
    .position           (position),
    .speaker_out        (speaker_out)
  );

endmodule

//--- tb/tb_spatial_audio.sv
/* testbench for the steered audio stage: clock, reset, host stimulus,
   bit history of the edge channels and assertion checks */

`timescale 1ns/100ps

module tb_spatial_audio;

  localparam int SAMPLE_PERIOD = 1000;
  localparam int NEAR_STEP     = 4;
  localparam int SIDE_STEP     = 6;
  localparam int DELAY_DEPTH   = 48;
  localparam int NCH           = spatial_pkg::NUM_CHANNELS;
  localparam int HIST_DEPTH    = 64;   // deeper than 7*SIDE_STEP
  localparam int RESET_CYCLES  = 16;
  localparam int REQ_TIMEOUT   = SAMPLE_PERIOD + 10;
  localparam int DENSITY_RUNS  = 4;
  localparam int CHECK_CYCLES  = 80;   // checked clocks per position

  logic                   PWM_ADC_CLOCK_100M = 1'b0;
  logic                   arst_n;
  spatial_pkg::audio_in_t audio_in;
  spatial_pkg::ctrl_in_t  ctrl_in;
  logic                   sample_req;
  logic [NCH-1:0]         speaker_out;

  logic [31:0] lcg_state = 32'hb998;
  int          cyc;                    // clocks since reset release
  logic        hist0 [HIST_DEPTH];     // speaker_out[0], index = clocks ago
  logic        hist7 [HIST_DEPTH];     // speaker_out[7], reference when mirrored
  logic        chk_en;
  logic        chk_mirror;
  int          chk_step;
  int          pace_errs   = 0;
  int          reset_errs  = 0;
  int          dens_errs   = 0;
  int          steer_errs  = 0;

  // ==============================
  // DUT, clock
  // ==============================
  spatial_audio_top #(
    .SAMPLE_PERIOD (SAMPLE_PERIOD),
    .NEAR_STEP     (NEAR_STEP),
    .SIDE_STEP     (SIDE_STEP),
    .DELAY_DEPTH   (DELAY_DEPTH)
  ) dut (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .audio_in           (audio_in),
    .ctrl_in            (ctrl_in),
    .sample_req         (sample_req),
    .speaker_out        (speaker_out)
  );

  always #5 PWM_ADC_CLOCK_100M = ~PWM_ADC_CLOCK_100M;  // 100 MHz

  always @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // request strobe never lasts two clocks
  assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
                   sample_req |=> !sample_req)
    else begin
      pace_errs++;
      $display("ERR sample_req got 0x1 exp 0x0 on second clock at %0t", $time);
    end

  // ==============================
  // monitor, sampled mid cycle
  // ==============================
  always @(negedge PWM_ADC_CLOCK_100M) begin : monitor
    logic exp_req;
    logic ref_bit;
    int   tap;
    // one strobe every period, first one a full period after release
    exp_req = arst_n && (cyc != 0) && ((cyc % SAMPLE_PERIOD) == 0);
    assert (sample_req === exp_req) else begin
      pace_errs++;
      $display("ERR sample_req got 0x%h exp 0x%h at cycle %0d", sample_req, exp_req, cyc);
    end
    if (!arst_n) begin
      assert (speaker_out === '0) else begin
        reset_errs++;
        $display("ERR speaker_out got 0x%h exp 0x%h in reset", speaker_out, 8'h00);
      end
    end
    for (int k = HIST_DEPTH - 1; k > 0; k--) begin
      hist0[k] = hist0[k-1];
      hist7[k] = hist7[k-1];
    end
    hist0[0] = speaker_out[0];
    hist7[0] = speaker_out[NCH-1];
    if (chk_en) begin
      for (int c = 0; c < NCH; c++) begin
        // left side counts from channel 0, right side from channel 7
        tap     = chk_mirror ? chk_step * (NCH - 1 - c) : chk_step * c;
        ref_bit = chk_mirror ? hist7[tap] : hist0[tap];
        assert (speaker_out[c] === ref_bit) else begin
          steer_errs++;
          $display("ERR speaker_out[%0d] got 0x%h exp 0x%h (delay %0d) at %0t",
                   c, speaker_out[c], ref_bit, tap, $time);
        end
      end
    end
  end

  // ==============================
  // random samples
  // ==============================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0000, lcg_state[31:16]};  // upper half, better period
  endfunction

  function automatic spatial_pkg::sample_t rand_sample();
    logic [31:0] r;
    r = lcg_next();
    return spatial_pkg::sample_t'(r % 32'd1001);  // 0..FULL_SCALE
  endfunction

  // ==============================
  // host side tasks
  // ==============================
  task automatic wait_sample_req(output bit ok);
    int n;
    n = 0;
    @(negedge PWM_ADC_CLOCK_100M);
    while (!sample_req && n < REQ_TIMEOUT) begin
      @(negedge PWM_ADC_CLOCK_100M);
      n++;
    end
    ok = sample_req;
    if (!ok) begin
      $display("timeout: no sample request after %0d clocks", REQ_TIMEOUT);
    end
  endtask

  task automatic send_ctrl(input spatial_pkg::ctrl_word_t word);
    @(posedge PWM_ADC_CLOCK_100M);
    #1;
    chk_en         = 1'b0;  // tap pattern may move
    audio_in.valid = 1'b0;
    ctrl_in.valid  = 1'b1;
    ctrl_in.word   = word;
    @(posedge PWM_ADC_CLOCK_100M);
    #1;
    ctrl_in.valid = 1'b0;
  endtask

  // a new sample every clock keeps the pulse stream irregular
  task automatic steer_cycles(input int n, input bit do_check, input int step,
                              input bit mirror);
    for (int i = 0; i < n; i++) begin
      @(posedge PWM_ADC_CLOCK_100M);
      #1;
      audio_in.valid  = 1'b1;
      audio_in.sample = rand_sample();
      chk_step        = step;
      chk_mirror      = mirror;
      chk_en          = do_check;
    end
  endtask

  task automatic settle_and_check(input int step, input bit mirror, input int settle);
    steer_cycles(settle, 1'b0, step, mirror);
    steer_cycles(CHECK_CYCLES, 1'b1, step, mirror);
  endtask

  // ==============================
  // test phases
  // ==============================
  task automatic run_density(output bit ok);
    spatial_pkg::sample_t s;
    int ones;
    int exp_ones;
    ok = 1'b1;
    for (int i = 0; i < DENSITY_RUNS; i++) begin
      if (ok) begin
        wait_sample_req(ok);
      end
      if (ok) begin
        s = rand_sample();
        exp_ones = int'(s);
        @(posedge PWM_ADC_CLOCK_100M);
        #1;
        audio_in.valid  = 1'b1;
        audio_in.sample = s;
        @(posedge PWM_ADC_CLOCK_100M);
        #1;
        audio_in.valid = 1'b0;
        repeat (SAMPLE_PERIOD) @(negedge PWM_ADC_CLOCK_100M);  // settling window
        ones = 0;
        repeat (SAMPLE_PERIOD) begin
          @(negedge PWM_ADC_CLOCK_100M);
          ones += int'(speaker_out[0]);
        end
        assert ((ones + 1 >= exp_ones) && (ones <= exp_ones + 1)) else begin
          dens_errs++;
          $display("ERR speaker_out[0] ones got 0x%h exp 0x%h +-1", ones, exp_ones);
        end
      end
    end
  endtask

  task automatic run_steering();
    // front, then an unknown code, inside one frame
    send_ctrl(spatial_pkg::FRAME_MARKER);
    send_ctrl(32'd0);
    settle_and_check(0, 1'b0, 2);
    send_ctrl(32'd9);
    settle_and_check(0, 1'b0, 2);
    send_ctrl(spatial_pkg::FRAME_MARKER);
    // stray word outside a frame, still front
    send_ctrl(32'd2);
    settle_and_check(0, 1'b0, DELAY_DEPTH);
    // left, left-front, right-front in one frame
    send_ctrl(spatial_pkg::FRAME_MARKER);
    send_ctrl(32'd2);
    settle_and_check(SIDE_STEP, 1'b0, DELAY_DEPTH);
    send_ctrl(32'd1);
    settle_and_check(NEAR_STEP, 1'b0, DELAY_DEPTH);
    send_ctrl(32'd3);
    settle_and_check(NEAR_STEP, 1'b1, DELAY_DEPTH);
    send_ctrl(spatial_pkg::FRAME_MARKER);
    // marker, right, marker
    send_ctrl(spatial_pkg::FRAME_MARKER);
    send_ctrl(32'd4);
    send_ctrl(spatial_pkg::FRAME_MARKER);
    settle_and_check(SIDE_STEP, 1'b1, DELAY_DEPTH);
    send_ctrl(32'd1);  // out of frame, right must stay
    settle_and_check(SIDE_STEP, 1'b1, DELAY_DEPTH);
  endtask

  task automatic end_run(input bit timed_out);
    int total;
    total = pace_errs + reset_errs + dens_errs + steer_errs;
    $display("errors: pacing %0d reset %0d density %0d steering %0d total %0d",
             pace_errs, reset_errs, dens_errs, steer_errs, total);
    if (!timed_out && total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin : stimulus
    bit ok;
    audio_in   = '0;
    ctrl_in    = '0;
    arst_n     = 1'b0;
    chk_en     = 1'b0;
    chk_mirror = 1'b0;
    chk_step   = 0;
    repeat (RESET_CYCLES) @(posedge PWM_ADC_CLOCK_100M);
    #1;
    arst_n = 1'b1;
    run_density(ok);  // front position from reset
    if (ok) begin
      run_steering();
    end
    end_run(!ok);
  end

endmodule

//--- project.f
common/spatial_pkg.sv
design/sample_pacer.sv
modulator/sigma_delta_mod.sv
design/position_framer.sv
steering/beam_steer.sv
design/spatial_audio_top.sv
tb/tb_spatial_audio.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, search the output for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_spatial_audio -o sim_tb \
  && out="$(./obj_dir/sim_tb)" \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -qx "Everything OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
